// File: design/radio_ctrl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types and address map for the radio control plane.
// Each block decodes its own addresses from set_bus_t.
////////////////////////////////////////////////////////////////////////////

package radio_ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus
   ////////////////////////////////////////////////////////////////////////////

   // One write per cycle while stb is high
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // Block base addresses
   // Misc: +0 config word 0, +1 config word 1, +2 clock sync
   localparam logic [7:0] SR_MISC   = 8'd0;
   // Time: +0 time high, +1 time low, +2 load command
   localparam logic [7:0] SR_TIME64 = 8'd192;
   // GPIO: +0 idle, +1 rx, +2 tx, +3 fdx, +4 direction
   localparam logic [7:0] SR_GPIO   = 8'd224;

   ////////////////////////////////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////////////////////////////////

   // Word indices, all others read as all ones
   localparam logic [3:0] RB_COMPAT  = 4'd0;
   localparam logic [3:0] RB_GPIO    = 4'd1;
   localparam logic [3:0] RB_CONFIG0 = 4'd2;
   localparam logic [3:0] RB_CONFIG1 = 4'd3;
   localparam logic [3:0] RB_TIME_HI = 4'd4;
   localparam logic [3:0] RB_TIME_LO = 4'd5;
   localparam logic [3:0] RB_PPS_HI  = 4'd6;
   localparam logic [3:0] RB_PPS_LO  = 4'd7;

   // Major in upper half, minor in lower half
   // bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = {16'd11, 16'd1};

   ////////////////////////////////////////////////////////////////////////////
   // GPIO
   ////////////////////////////////////////////////////////////////////////////

   localparam int GPIO_WIDTH = 32;

   // Encoded as {run_tx, run_rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_t;

endpackage

// File: design/misc_settings.sv
////////////////////////////////////////////////////////////////////////////
// Config words have no reset and survive rst_n_i.
// Clock sync word: bit 0 enable, bit 1 invert. Output is combinational.
////////////////////////////////////////////////////////////////////////////

module misc_settings (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  radio_ctrl_pkg::set_bus_t set_bus_i,
   input  logic                     pps_i,
   output logic [31:0]              config_word0_o,
   output logic [31:0]              config_word1_o,
   output logic                     clock_sync_o
);

   import radio_ctrl_pkg::*;

   logic clock_sync_enb;
   logic clock_sync_inv;

   // Persistent configuration words
   always_ff @(posedge clk) begin
      if (set_bus_i.stb && (set_bus_i.addr == SR_MISC)) begin
         config_word0_o <= set_bus_i.data;
      end
      if (set_bus_i.stb && (set_bus_i.addr == SR_MISC + 8'd1)) begin
         config_word1_o <= set_bus_i.data;
      end
   end

   // Clock sync control
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         clock_sync_enb <= 1'b0;
         clock_sync_inv <= 1'b0;
      end else if (set_bus_i.stb && (set_bus_i.addr == SR_MISC + 8'd2)) begin
         clock_sync_enb <= set_bus_i.data[0];
         clock_sync_inv <= set_bus_i.data[1];
      end
   end

   // Reference clock sync follows the raw PPS pin
   assign clock_sync_o = clock_sync_enb ? (pps_i ^ clock_sync_inv) : 1'b0;

endmodule

// File: design/time_64bit.sv
////////////////////////////////////////////////////////////////////////////
// Free-running 64-bit time. Command bit 0 set loads now, clear arms a load
// on the next synchronized PPS rising edge (three clocks after the pin).
////////////////////////////////////////////////////////////////////////////

module time_64bit (
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  radio_ctrl_pkg::set_bus_t set_bus_i,
   input  logic                     pps_i,
   output logic [63:0]              vita_time_o,
   output logic [63:0]              vita_time_pps_o
);

   import radio_ctrl_pkg::*;

   logic [31:0] time_hi_q;
   logic [31:0] time_lo_q;
   logic        armed_q;
   logic        hi_wr;
   logic        lo_wr;
   logic        cmd_wr;
   logic        pps_meta;
   logic        pps_sync;
   logic        pps_dly;
   logic        pps_edge;

   assign hi_wr  = set_bus_i.stb && (set_bus_i.addr == SR_TIME64);
   assign lo_wr  = set_bus_i.stb && (set_bus_i.addr == SR_TIME64 + 8'd1);
   assign cmd_wr = set_bus_i.stb && (set_bus_i.addr == SR_TIME64 + 8'd2);

   // Staged load value
   always_ff @(posedge clk) begin
      if (hi_wr) begin
         time_hi_q <= set_bus_i.data;
      end
      if (lo_wr) begin
         time_lo_q <= set_bus_i.data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         pps_meta <= 1'b0;
         pps_sync <= 1'b0;
         pps_dly  <= 1'b0;
      end else begin
         pps_meta <= pps_i;
         pps_sync <= pps_meta;
         pps_dly  <= pps_sync;
      end
   end

   assign pps_edge = pps_sync & ~pps_dly;

   ////////////////////////////////////////////////////////////////////////////
   // Counter, load and PPS latch
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         armed_q         <= 1'b0;
      end else begin
         // Immediate load or armed load on the PPS edge
         if ((cmd_wr && set_bus_i.data[0]) || (armed_q && pps_edge)) begin
            vita_time_o <= {time_hi_q, time_lo_q};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end

         // A new command always replaces a pending one
         if (cmd_wr) begin
            armed_q <= ~set_bus_i.data[0];
         end else if (pps_edge) begin
            armed_q <= 1'b0;
         end

         if (pps_edge) begin
            vita_time_pps_o <= vita_time_o;
         end
      end
   end

endmodule

// File: design/gpio_atr.sv
////////////////////////////////////////////////////////////////////////////
// Output pins follow the ATR register of the current run state.
// Direction register drives the output enables directly.
////////////////////////////////////////////////////////////////////////////

module gpio_atr (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  radio_ctrl_pkg::set_bus_t            set_bus_i,
   input  logic                                run_rx_i,
   input  logic                                run_tx_i,
   output logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_out_o,
   output logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_oe_o
);

   import radio_ctrl_pkg::*;

   logic [GPIO_WIDTH-1:0] atr_regs [4];
   logic [GPIO_WIDTH-1:0] out_next;
   logic [7:0]            wr_offset;
   logic [1:0]            wr_idx;
   logic                  wr_atr;
   logic                  wr_ddr;
   atr_state_t            state;

   ////////////////////////////////////////////////////////////////////////////
   // Register decode
   ////////////////////////////////////////////////////////////////////////////

   assign wr_offset = set_bus_i.addr - SR_GPIO;
   assign wr_idx    = wr_offset[1:0];
   assign wr_atr    = set_bus_i.stb && (wr_offset < 8'd4);
   assign wr_ddr    = set_bus_i.stb && (wr_offset == 8'd4);

   // One value register per run state
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         for (int i = 0; i < 4; i++) begin
            atr_regs[i] <= '0;
         end
      end else if (wr_atr) begin
         atr_regs[wr_idx] <= set_bus_i.data[GPIO_WIDTH-1:0];
      end
   end

   // Direction, 1 drives the pin
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         gpio_oe_o <= '0;
      end else if (wr_ddr) begin
         gpio_oe_o <= set_bus_i.data[GPIO_WIDTH-1:0];
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // State select
   ////////////////////////////////////////////////////////////////////////////

   assign state = atr_state_t'({run_tx_i, run_rx_i});

   // Bypass a write to the active state's register so the pins
   // change on the same edge as the register itself
   always_comb begin
      if (wr_atr && (wr_idx == state)) begin
         out_next = set_bus_i.data[GPIO_WIDTH-1:0];
      end else begin
         out_next = atr_regs[state];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         gpio_out_o <= '0;
      end else begin
         gpio_out_o <= out_next;
      end
   end

endmodule

// File: design/readback_mux.sv
////////////////////////////////////////////////////////////////////////////
// Data appears one clock after the address. Reading TIME_HI snapshots the
// time so that a following TIME_LO read returns the matching low half.
////////////////////////////////////////////////////////////////////////////

module readback_mux (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic [3:0]                          rb_addr_i,
   input  logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_in_i,
   input  logic [31:0]                         config_word0_i,
   input  logic [31:0]                         config_word1_i,
   input  logic [63:0]                         vita_time_i,
   input  logic [63:0]                         vita_time_pps_i,
   output logic [31:0]                         rb_data_o
);

   import radio_ctrl_pkg::*;

   // Low half of the time seen by the last high read
   logic [31:0] time_lo_snap;

   always_ff @(posedge clk) begin
      if (rb_addr_i == RB_TIME_HI) begin
         time_lo_snap <= vita_time_i[31:0];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         rb_data_o <= '0;
      end else begin
         case (rb_addr_i)
            RB_COMPAT:  rb_data_o <= COMPAT_NUM;
            RB_GPIO:    rb_data_o <= 32'(gpio_in_i);
            RB_CONFIG0: rb_data_o <= config_word0_i;
            RB_CONFIG1: rb_data_o <= config_word1_i;
            RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
            RB_TIME_LO: rb_data_o <= time_lo_snap;
            RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
            RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
            default:    rb_data_o <= '1;
         endcase
      end
   end

endmodule

// File: design/radio_ctrl_core.sv
////////////////////////////////////////////////////////////////////////////
// Control plane top. Settings bus is driven directly, no flow control.
// Pads are split into separate out, output-enable and in ports.
////////////////////////////////////////////////////////////////////////////

module radio_ctrl_core (
   input  logic                                clk,
   input  logic                                rst_n_i,
   input  logic                                set_stb_i,
   input  logic [7:0]                          set_addr_i,
   input  logic [31:0]                         set_data_i,
   input  logic [3:0]                          rb_addr_i,
   output logic [31:0]                         rb_data_o,
   input  logic                                pps_i,
   output logic                                clock_sync_o,
   input  logic                                run_rx_i,
   input  logic                                run_tx_i,
   input  logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_in_i,
   output logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_out_o,
   output logic [radio_ctrl_pkg::GPIO_WIDTH-1:0] gpio_oe_o
);

   import radio_ctrl_pkg::*;

   set_bus_t    set_bus;
   logic [31:0] config_word0;
   logic [31:0] config_word1;
   logic [63:0] vita_time;
   logic [63:0] vita_time_pps;

   assign set_bus = '{stb: set_stb_i, addr: set_addr_i, data: set_data_i};

   misc_settings u_misc (
      .clk(clk), .rst_n_i(rst_n_i), .set_bus_i(set_bus), .pps_i(pps_i),
      .config_word0_o(config_word0), .config_word1_o(config_word1),
      .clock_sync_o(clock_sync_o));

   time_64bit u_time (
      .clk(clk), .rst_n_i(rst_n_i), .set_bus_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   gpio_atr u_gpio (
      .clk(clk), .rst_n_i(rst_n_i), .set_bus_i(set_bus),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o));

   readback_mux u_rb (
      .clk(clk), .rst_n_i(rst_n_i), .rb_addr_i(rb_addr_i), .gpio_in_i(gpio_in_i),
      .config_word0_i(config_word0), .config_word1_i(config_word1),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps), .rb_data_o(rb_data_o));

endmodule

// File: dv/radio_ctrl_tb.sv
////////////////////////////////////////////////////////////////////////////
// Drives radio_ctrl_core through config, time, GPIO and clock sync.
// Inputs change 1 unit after the rising edge. Outputs compared at falling edge.
////////////////////////////////////////////////////////////////////////////

module radio_ctrl_tb;

   import radio_ctrl_pkg::*;

   // Upper bound of the clock cycles used by the sequence
   localparam int         STIM_CYCLES = 80;
   localparam logic [1:0] CHK_RB      = 2'd0;
   localparam logic [1:0] CHK_OUT     = 2'd1;
   localparam logic [1:0] CHK_OE      = 2'd2;
   localparam logic [1:0] CHK_SYNC    = 2'd3;

   typedef struct packed {
      logic [31:0] due;
      logic [1:0]  kind;
      logic [3:0]  idx;
      logic [31:0] exp;
   } check_t;

   logic                  clk;
   logic                  rst_n_i;
   logic                  set_stb_i;
   logic [7:0]            set_addr_i;
   logic [31:0]           set_data_i;
   logic [3:0]            rb_addr_i;
   logic [31:0]           rb_data_o;
   logic                  pps_i;
   logic                  clock_sync_o;
   logic                  run_rx_i;
   logic                  run_tx_i;
   logic [GPIO_WIDTH-1:0] gpio_in_i;
   logic [GPIO_WIDTH-1:0] gpio_out_o;
   logic [GPIO_WIDTH-1:0] gpio_oe_o;

   // Register model
   logic [31:0] cfg_m [2];
   logic [31:0] atr_m [4];
   logic [31:0] ddr_m;
   logic [31:0] stage_hi;
   logic [31:0] stage_lo;
   logic [63:0] load_val;
   logic [31:0] load_cyc;
   logic [31:0] snap_m;
   logic [63:0] pps_latch_m;
   logic        armed_m;
   logic        sync_en_m;
   logic        sync_inv_m;
   logic [31:0] cyc;
   logic [31:0] lfsr;
   check_t      pending [$];

   radio_ctrl_core UUT (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   initial begin
      #(STIM_CYCLES * 8 + 400);
      $display("Watchdog expired before the test sequence finished");
      $display("TEST FAILED");
      $fatal(1);
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random source and reference model
   ////////////////////////////////////////////////////////////////////////////

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr = lfsr_step(lfsr);
         w    = {w[30:0], lfsr[0]};
      end
      return w;
   endfunction

   // Counter value right after edge n
   function automatic logic [63:0] model_time(input logic [31:0] n);
      return load_val + 64'(n) - 64'(load_cyc);
   endfunction

   function automatic logic [31:0] expected_value(input logic [1:0] kind,
                                                  input logic [3:0] idx);
      logic [63:0] t;
      t = model_time(cyc);
      case (kind)
         CHK_OUT:  return atr_m[{run_tx_i, run_rx_i}];
         CHK_OE:   return ddr_m;
         CHK_SYNC: return {31'd0, sync_en_m & (pps_i ^ sync_inv_m)};
         default: begin
            case (idx)
               RB_COMPAT:  return 32'h000b_0001;
               RB_GPIO:    return gpio_in_i;
               RB_CONFIG0: return cfg_m[0];
               RB_CONFIG1: return cfg_m[1];
               RB_TIME_HI: return t[63:32];
               RB_TIME_LO: return snap_m;
               RB_PPS_HI:  return pps_latch_m[63:32];
               RB_PPS_LO:  return pps_latch_m[31:0];
               default:    return '1;
            endcase
         end
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      logic [63:0] t;
      // High read snapshots the live time
      if (rb_addr_i == RB_TIME_HI) begin
         t      = model_time(cyc);
         snap_m = t[31:0];
      end
      @(posedge clk);
      #1;
      cyc = cyc + 1;
   endtask

   task automatic queue_check(input logic [31:0] at_cyc, input logic [1:0] kind,
                              input logic [3:0] idx);
      check_t c;
      c = '{at_cyc, kind, idx, expected_value(kind, idx)};
      pending.push_back(c);
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      next_cycle();
      set_stb_i = 1'b0;
      case (addr)
         SR_MISC:          cfg_m[0] = data;
         SR_MISC + 8'd1:   cfg_m[1] = data;
         SR_MISC + 8'd2: begin
            sync_en_m  = data[0];
            sync_inv_m = data[1];
         end
         SR_TIME64:        stage_hi = data;
         SR_TIME64 + 8'd1: stage_lo = data;
         SR_TIME64 + 8'd2: begin
            armed_m = ~data[0];
            if (data[0]) begin
               load_val = {stage_hi, stage_lo};
               load_cyc = cyc;
            end
         end
         SR_GPIO + 8'd4:   ddr_m = data;
         default: begin
            if (addr >= SR_GPIO && addr < SR_GPIO + 8'd4) begin
               atr_m[addr[1:0]] = data;
            end
         end
      endcase
   endtask

   task automatic read_word(input logic [3:0] idx);
      rb_addr_i = idx;
      queue_check(cyc + 1, CHK_RB, idx);
      next_cycle();
   endtask

   task automatic set_run_state(input logic rx, input logic tx);
      run_rx_i = rx;
      run_tx_i = tx;
      queue_check(cyc + 1, CHK_OUT, 4'd0);
      queue_check(cyc + 1, CHK_OE, 4'd0);
      next_cycle();
   endtask

   task automatic apply_reset();
      rb_addr_i = 4'hf;
      rst_n_i   = 1'b0;
      repeat (5) next_cycle();
      rst_n_i     = 1'b1;
      load_val    = '0;
      load_cyc    = cyc;
      pps_latch_m = '0;
      armed_m     = 1'b0;
      sync_en_m   = 1'b0;
      sync_inv_m  = 1'b0;
      ddr_m       = '0;
      for (int i = 0; i < 4; i++) begin
         atr_m[i] = '0;
      end
   endtask

   task automatic pulse_pps();
      pps_i = 1'b1;
      // Two sync flops, then the edge detect
      repeat (2) next_cycle();
      pps_latch_m = model_time(cyc);
      next_cycle();
      if (armed_m) begin
         load_val = {stage_hi, stage_lo};
         load_cyc = cyc;
      end
      armed_m = 1'b0;
      repeat (3) next_cycle();
      pps_i = 1'b0;
      repeat (4) next_cycle();
   endtask

   task automatic sync_level(input logic level);
      pps_i = level;
      queue_check(cyc, CHK_SYNC, 4'd0);
      next_cycle();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      check_t      c;
      logic [31:0] actual;
      while (pending.size() > 0 && pending[0].due <= cyc) begin
         c = pending.pop_front();
         case (c.kind)
            CHK_RB:  actual = rb_data_o;
            CHK_OUT: actual = gpio_out_o;
            CHK_OE:  actual = gpio_oe_o;
            default: actual = {31'd0, clock_sync_o};
         endcase
         assert (actual == c.exp) else begin
            $display("Mismatch at %0t: kind %0d index %0d read %h, expected %h",
                     $time, c.kind, c.idx, actual, c.exp);
            $display("TEST FAILED");
            $fatal(1);
         end
      end
   end

   initial begin
      rst_n_i    = 1'b0;
      set_stb_i  = 1'b0;
      set_addr_i = '0;
      set_data_i = '0;
      rb_addr_i  = 4'hf;
      pps_i      = 1'b0;
      run_rx_i   = 1'b0;
      run_tx_i   = 1'b0;
      gpio_in_i  = '0;
      cyc        = '0;
      lfsr       = 32'h66fa_4b95;
      snap_m     = '0;
      stage_hi   = '0;
      stage_lo   = '0;
      apply_reset();

      read_word(RB_COMPAT);
      read_word(4'd8);
      read_word(4'd15);

      // Config words keep their value through reset
      bus_write(SR_MISC, rand_bits(32));
      bus_write(SR_MISC + 8'd1, rand_bits(32));
      read_word(RB_CONFIG0);
      read_word(RB_CONFIG1);
      apply_reset();
      read_word(RB_CONFIG0);
      read_word(RB_CONFIG1);

      // Immediate load with low word near wrap
      bus_write(SR_TIME64, rand_bits(32));
      bus_write(SR_TIME64 + 8'd1, 32'hffff_fff8);
      bus_write(SR_TIME64 + 8'd2, 32'd1);
      repeat (2) next_cycle();
      read_word(RB_TIME_HI);
      read_word(RB_COMPAT);
      read_word(RB_TIME_LO);
      repeat (4) next_cycle();
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);

      // Armed load waits for the PPS edge
      bus_write(SR_TIME64, rand_bits(32));
      bus_write(SR_TIME64 + 8'd1, rand_bits(32));
      bus_write(SR_TIME64 + 8'd2, 32'd0);
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);
      pulse_pps();
      read_word(RB_PPS_HI);
      read_word(RB_PPS_LO);
      read_word(RB_TIME_HI);
      read_word(RB_TIME_LO);

      // Four ATR words plus direction
      for (int i = 0; i < 5; i++) begin
         bus_write(SR_GPIO + 8'(i), rand_bits(32));
      end
      queue_check(cyc, CHK_OE, 4'd0);
      set_run_state(1'b0, 1'b0);
      set_run_state(1'b1, 1'b0);
      set_run_state(1'b0, 1'b1);
      set_run_state(1'b1, 1'b1);
      // Write to the active state's word
      bus_write(SR_GPIO + 8'd3, rand_bits(32));
      queue_check(cyc, CHK_OUT, 4'd0);
      set_run_state(1'b0, 1'b0);
      gpio_in_i = rand_bits(32);
      read_word(RB_GPIO);

      // Clock sync off, plain, inverted
      sync_level(1'b1);
      bus_write(SR_MISC + 8'd2, 32'd1);
      sync_level(1'b0);
      sync_level(1'b1);
      bus_write(SR_MISC + 8'd2, 32'd3);
      sync_level(1'b0);
      sync_level(1'b1);
      sync_level(1'b0);

      repeat (2) next_cycle();
      if (pending.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("Checks were left in the queue without being compared");
         $display("TEST FAILED");
         $fatal(1);
      end
   end

endmodule

// File: files.f
design/radio_ctrl_pkg.sv
design/misc_settings.sv
design/time_64bit.sv
design/gpio_atr.sv
design/readback_mux.sv
design/radio_ctrl_core.sv
dv/radio_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module radio_ctrl_tb -f files.f \
   -o radio_ctrl_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/radio_ctrl_sim > sim.log 2>&1 || echo "Simulator returned a nonzero status"
cat sim.log
[ -s sim.log ] || { echo "Simulation log is empty"; exit 1; }
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
echo "Simulation passed"
exit 0
